// File: build.f
source/bus_pkg.sv
source/regmap_pkg.sv
source/wb_decoder.sv
source/register_file.sv
source/wb_ram.sv
source/pet_control_top.sv
sim/tb_pet_control.sv

// File: build.sh
#!/bin/sh
# Compile the control bus slice and its testbench with Verilator, then run it
set -e
cd "$(dirname "$0")"

rm -f sim.log
verilator --binary --timing -f build.f --top-module tb_pet_control -o tb_pet_control

# The log decides the result, so a fatal exit must not stop the script here
./obj_dir/tb_pet_control > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAILED" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi
if ! grep -q "TEST PASSED" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
echo "Simulation passed"

// File: sim/tb_pet_control.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Directed testbench for the control bus slice
// Clock, reset, Wishbone access tasks, reference model and tests
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module tb_pet_control
    import bus_pkg::*, regmap_pkg::*;
();
    localparam int      RAM_ADDR_WIDTH = 10;
    localparam int      RAM_DEPTH      = 2 ** RAM_ADDR_WIDTH;
    localparam int      TEST_CYCLES    = 240;              // Summed budget of all tests
    localparam int      TIMEOUT_CYCLES = 4 * TEST_CYCLES;
    localparam wb_req_t IDLE_REQ       = '0;

    logic       wb_clock;
    logic       rst;
    wb_req_t    wb_req;
    wb_rsp_t    wb_rsp;
    logic       cpu_ready;
    logic       cpu_reset;
    logic       cpu_nmi;
    logic       video_graphic;
    logic       video_col_80;
    logic [1:0] video_ram_mask;

    // Reference model
    wb_data_t    ram_model [RAM_DEPTH];
    wb_data_t    reg_model [REG_COUNT];
    wb_addr_t    ram_written [$];          // RAM addresses with known contents
    wb_req_t     burst_q [$];              // Accesses queued for bus_burst
    logic [31:0] rng_state   = 32'h8b11_5aa8;
    int          cycle_count = 0;
    int          failures    = 0;

    pet_control_top #(
        .RAM_ADDR_WIDTH(RAM_ADDR_WIDTH)
    ) uut (
        .wb_clock_i         (wb_clock),
        .rst_i              (rst),
        .wb_req_i           (wb_req),
        .wb_rsp_o           (wb_rsp),
        .cpu_ready_o        (cpu_ready),
        .cpu_reset_o        (cpu_reset),
        .cpu_nmi_o          (cpu_nmi),
        .video_graphic_i    (video_graphic),
        .video_col_80_mode_o(video_col_80),
        .video_ram_mask_o   (video_ram_mask)
    );

    initial begin
        wb_clock = 1'b0;
        forever #5 wb_clock = ~wb_clock;   // 100 MHz
    end

    // Run limit
    always @(posedge wb_clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the tests did not finish", cycle_count);
            $display("TEST FAILED");
            $fatal(1, "Simulation timeout");
        end
    end

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // Applies one access to the model, returns the value a read sees
    function automatic wb_data_t model_access(input wb_addr_t addr, input logic we,
                                              input wb_data_t data);
        wb_data_t old;
        old = 8'h00;                        // Unmapped reads as zero
        if (addr[11:2] == REG_BASE[11:2]) begin
            old = reg_model[addr[1:0]];
            if (addr[1:0] == REG_VIDEO) begin
                old[REG_VIDEO_GRAPHICS_BIT] = video_graphic;  // Live level
            end
            if (we) begin
                reg_model[addr[1:0]] = data;
            end
        end else if (addr[11:10] == RAM_BASE[11:10]) begin
            old = ram_model[addr[9:0]];
            if (we) begin
                ram_model[addr[9:0]] = data;
            end
        end
        return old;
    endfunction

    task automatic report_failure(input string what);
        failures++;
        $display("ERROR at %0t: %s", $time, what);
        $display("TEST FAILED");
        $fatal(1, "Check failed");
    endtask

    task automatic check_value(input string name, input logic [7:0] expected,
                               input logic [7:0] actual);
        if (actual !== expected) begin
            failures++;
            $display("MISMATCH time=%0t signal=%s expected=%02h actual=%02h",
                     $time, name, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "Value mismatch");
        end
    endtask

    // Control pins against the model registers
    task automatic check_pins();
        wb_data_t cpu;
        wb_data_t video;
        cpu   = reg_model[REG_CPU];
        video = reg_model[REG_VIDEO];
        check_value("cpu_ready_o", 8'(cpu[REG_CPU_READY_BIT]), 8'(cpu_ready));
        check_value("cpu_reset_o", 8'(cpu[REG_CPU_RESET_BIT]), 8'(cpu_reset));
        check_value("cpu_nmi_o", 8'(cpu[REG_CPU_NMI_BIT]), 8'(cpu_nmi));
        check_value("video_col_80_mode_o", 8'(video[REG_VIDEO_COL_80_BIT]), 8'(video_col_80));
        check_value("video_ram_mask_o", {7'b0, video[REG_VIDEO_COL_80_BIT]},
                    8'(video_ram_mask));
    endtask

    // One access, ack expected on the following edge
    task automatic bus_access(input wb_addr_t addr, input logic we, input wb_data_t data,
                              output wb_data_t rdata);
        @(posedge wb_clock);
        wb_req <= '{addr: addr, data: data, we: we, cyc: 1'b1, stb: 1'b1};
        @(posedge wb_clock);
        wb_req <= IDLE_REQ;
        @(negedge wb_clock);
        if (wb_rsp.ack !== 1'b1) begin
            report_failure($sformatf("no ack one cycle after the access to %03h", addr));
        end
        check_value("wb_rsp_o.stall", 8'h00, 8'(wb_rsp.stall));  // No back-pressure
        rdata = wb_rsp.data;
    endtask

    task automatic bus_write(input wb_addr_t addr, input wb_data_t data);
        wb_data_t unused;
        void'(model_access(addr, 1'b1, data));
        bus_access(addr, 1'b1, data, unused);
    endtask

    task automatic bus_read(input wb_addr_t addr);
        wb_data_t expected;
        wb_data_t rdata;
        expected = model_access(addr, 1'b0, 8'h00);
        bus_access(addr, 1'b0, 8'h00, rdata);
        check_value("wb_rsp_o.data", expected, rdata);
    endtask

    task automatic push_access(input wb_addr_t addr, input logic we, input wb_data_t data);
        burst_q.push_back('{addr: addr, data: data, we: we, cyc: 1'b1, stb: 1'b1});
    endtask

    // Queued accesses on consecutive cycles, each ack one cycle later
    task automatic bus_burst();
        wb_data_t expected [$];
        logic     was_read [$];
        int       n;
        n = burst_q.size();
        for (int i = 0; i <= n + 1; i++) begin
            @(posedge wb_clock);
            if (i < n) begin
                wb_req <= burst_q[i];
                expected.push_back(model_access(burst_q[i].addr, burst_q[i].we,
                                                burst_q[i].data));
                was_read.push_back(!burst_q[i].we);
            end else begin
                wb_req <= IDLE_REQ;
            end
            @(negedge wb_clock);
            if (i >= 1 && i <= n) begin
                check_value("wb_rsp_o.ack", 8'h01, 8'(wb_rsp.ack));
                if (was_read[i-1]) begin
                    check_value("wb_rsp_o.data", expected[i-1], wb_rsp.data);
                end
            end else begin
                check_value("wb_rsp_o.ack", 8'h00, 8'(wb_rsp.ack));  // No stray ack
            end
        end
        burst_q.delete();
    endtask

    task automatic test_power_on();
        check_value("wb_rsp_o.ack", 8'h00, 8'(wb_rsp.ack));
        check_pins();
        bus_read(REG_BASE | 12'(REG_CPU));
        bus_read(REG_BASE | 12'(REG_VIDEO));
    endtask

    task automatic test_cpu_controls();
        logic [31:0] rnd;
        wb_data_t    data;
        for (int combo = 0; combo < 8; combo++) begin
            rnd  = next_random();
            data = {rnd[7:3], combo[2:0]};  // Upper bits are plain storage
            bus_write(REG_BASE | 12'(REG_CPU), data);
            check_pins();                   // Pins follow from the ack cycle
            bus_read(REG_BASE | 12'(REG_CPU));
            check_pins();
        end
    endtask

    task automatic test_video_mode();
        bus_write(REG_BASE | 12'(REG_VIDEO), 8'h01);     // 80 columns on
        check_pins();
        bus_read(REG_BASE | 12'(REG_VIDEO));
        bus_write(REG_BASE | 12'(REG_VIDEO), 8'h03);     // Graphics bit against input 0
        bus_read(REG_BASE | 12'(REG_VIDEO));
        @(posedge wb_clock);
        video_graphic <= 1'b1;
        @(negedge wb_clock);                             // Level settled for the model
        bus_read(REG_BASE | 12'(REG_VIDEO));
        bus_write(REG_BASE | 12'(REG_VIDEO), 8'h00);     // Back to 40 columns
        check_pins();
        bus_read(REG_BASE | 12'(REG_VIDEO));
        @(posedge wb_clock);
        video_graphic <= 1'b0;
        @(negedge wb_clock);
        bus_read(REG_BASE | 12'(REG_VIDEO));
        check_pins();
    endtask

    task automatic test_ram_random();
        logic [31:0] rnd;
        wb_addr_t    addr;
        wb_data_t    expected;
        wb_data_t    rdata;
        for (int i = 0; i < 32; i++) begin
            rnd  = next_random();
            addr = RAM_BASE | {2'b00, rnd[9:0]};
            ram_written.push_back(addr);
            bus_write(addr, rnd[17:10]);
        end
        foreach (ram_written[i]) begin
            bus_read(ram_written[i]);
        end
        // Write then read on the very next cycle
        addr = ram_written[3];
        rnd  = next_random();
        push_access(addr, 1'b1, rnd[7:0]);
        push_access(addr, 1'b0, 8'h00);
        bus_burst();
        // Read and write in one access returns the old byte
        expected = model_access(addr, 1'b1, 8'hA5);
        bus_access(addr, 1'b1, 8'hA5, rdata);
        check_value("wb_rsp_o.data", expected, rdata);
        bus_read(addr);
    endtask

    task automatic test_burst_mix();
        push_access(ram_written[5], 1'b1, 8'h3C);
        push_access(ram_written[5], 1'b0, 8'h00);
        push_access(12'h400, 1'b0, 8'h00);           // Gap between RAM and registers
        push_access(REG_BASE | 12'(REG_CPU), 1'b1, 8'h05);
        push_access(REG_BASE | 12'(REG_CPU), 1'b0, 8'h00);
        push_access(12'hC00, 1'b0, 8'h00);
        push_access(REG_BASE | 12'd2, 1'b1, 8'h9E);  // Scratch byte
        push_access(REG_BASE | 12'd2, 1'b0, 8'h00);
        push_access(ram_written[9], 1'b0, 8'h00);
        push_access(12'h804, 1'b1, 8'hFF);           // Just past the register window
        push_access(REG_BASE | 12'd3, 1'b0, 8'h00);
        push_access(ram_written[5], 1'b0, 8'h00);
        bus_burst();
        check_pins();
    endtask

    task automatic test_unmapped_write();
        wb_data_t rdata;
        bus_write(RAM_BASE, 8'h5A);
        bus_write(REG_BASE | 12'(REG_CPU), 8'h01);
        bus_access(12'hC00, 1'b1, 8'hA5, rdata);     // Aliases RAM 0 and CPU by low bits
        check_value("wb_rsp_o.data", 8'h00, rdata);
        bus_access(12'h400, 1'b1, 8'hC3, rdata);
        bus_access(12'h804, 1'b1, 8'h06, rdata);
        bus_read(RAM_BASE);
        bus_read(REG_BASE | 12'(REG_CPU));
        bus_read(12'hC00);
        check_pins();
    endtask

    initial begin
        rst           = 1'b1;
        wb_req        = IDLE_REQ;
        video_graphic = 1'b0;
        reg_model[0]  = 8'h02;              // Reset held, not ready, no NMI
        reg_model[1]  = 8'h00;
        reg_model[2]  = 8'h00;
        reg_model[3]  = 8'h00;
        repeat (4) @(posedge wb_clock);
        rst <= 1'b0;
        @(negedge wb_clock);

        test_power_on();
        test_cpu_controls();
        test_video_mode();
        test_ram_random();
        test_burst_mix();
        test_unmapped_write();

        if (failures == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end
endmodule

// File: source/bus_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Wishbone B4 bus widths and vector types
// Request and response structs, base addresses of the slave windows
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package bus_pkg;

    localparam int WB_ADDR_WIDTH = 12;     // 4 KiB byte address space
    localparam int DATA_WIDTH    = 8;      // Single byte lane, no byte selects

    typedef logic [WB_ADDR_WIDTH-1:0] wb_addr_t;  // Bus byte address
    typedef logic [DATA_WIDTH-1:0]    wb_data_t;  // Bus data byte

    // Master to slave, one access per cycle with cyc && stb
    typedef struct packed {
        wb_addr_t addr;
        wb_data_t data;     // Write data
        logic     we;       // 1 = write
        logic     cyc;
        logic     stb;
    } wb_req_t;

    // Slave to master
    typedef struct packed {
        wb_data_t data;     // Read data, valid with ack
        logic     ack;
        logic     stall;    // Never asserted by these slaves
    } wb_rsp_t;

    // Window starts
    localparam wb_addr_t REG_BASE = 12'h800;   // Control registers
    localparam wb_addr_t RAM_BASE = 12'h000;   // Scratch RAM

endpackage

// File: source/pet_control_top.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Control bus slice top level
// Decoder, control register file and scratch RAM on one Wishbone port
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module pet_control_top
    import bus_pkg::*;
#(
    parameter int RAM_ADDR_WIDTH = 10       // 1 KiB scratch RAM
) (
    input  logic          wb_clock_i,
    input  logic          rst_i,

    // External master, SPI bridge in the full machine
    input  wb_req_t       wb_req_i,
    output wb_rsp_t       wb_rsp_o,

    // CPU control
    output logic          cpu_ready_o,
    output logic          cpu_reset_o,
    output logic          cpu_nmi_o,

    // Video control
    input  logic          video_graphic_i,
    output logic          video_col_80_mode_o,
    output logic [11:10]  video_ram_mask_o
);
    logic    reg_sel;
    logic    ram_sel;
    wb_rsp_t reg_rsp;
    wb_rsp_t ram_rsp;

    wb_decoder #(
        .RAM_ADDR_WIDTH(RAM_ADDR_WIDTH)
    ) decoder (
        .wb_clock_i(wb_clock_i),
        .rst_i     (rst_i),
        .bus_req_i (wb_req_i),
        .bus_rsp_o (wb_rsp_o),
        .reg_sel_o (reg_sel),
        .ram_sel_o (ram_sel),
        .reg_rsp_i (reg_rsp),
        .ram_rsp_i (ram_rsp)
    );

    // Both slaves see the request as is, the select qualifies it
    register_file regs (
        .wb_clock_i         (wb_clock_i),
        .rst_i              (rst_i),
        .wb_req_i           (wb_req_i),
        .wb_sel_i           (reg_sel),
        .wb_rsp_o           (reg_rsp),
        .cpu_ready_o        (cpu_ready_o),
        .cpu_reset_o        (cpu_reset_o),
        .cpu_nmi_o          (cpu_nmi_o),
        .video_graphic_i    (video_graphic_i),
        .video_col_80_mode_o(video_col_80_mode_o),
        .video_ram_mask_o   (video_ram_mask_o)
    );

    wb_ram #(
        .RAM_ADDR_WIDTH(RAM_ADDR_WIDTH)
    ) ram (
        .wb_clock_i(wb_clock_i),
        .wb_req_i  (wb_req_i),
        .wb_sel_i  (ram_sel),
        .wb_rsp_o  (ram_rsp),
        .rst_i     (rst_i)
    );
endmodule

// File: source/register_file.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Control register file on the Wishbone bus
// CPU ready/reset/NMI and 80 column outputs, graphics status refresh
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module register_file
    import bus_pkg::*, regmap_pkg::*;
(
    input  logic          wb_clock_i,
    input  logic          rst_i,
    input  wb_req_t       wb_req_i,
    input  logic          wb_sel_i,             // Address is in the register window
    output wb_rsp_t       wb_rsp_o,

    // CPU control
    output logic          cpu_ready_o,
    output logic          cpu_reset_o,
    output logic          cpu_nmi_o,

    // Video control
    input  logic          video_graphic_i,      // VIA CA2, 0 = graphics, 1 = text
    output logic          video_col_80_mode_o,
    output logic [11:10]  video_ram_mask_o      // Video RAM address bits 11:10
);
    wb_data_t  regs [REG_COUNT];
    wb_data_t  rd_data_q;
    logic      ack_q;
    logic      access;
    reg_addr_t reg_idx;

    assign access  = wb_sel_i && wb_req_i.cyc && wb_req_i.stb;
    assign reg_idx = wb_req_i.addr[REG_ADDR_WIDTH-1:0];   // Low bits pick the register

    // Registers and ack
    always_ff @(posedge wb_clock_i) begin
        if (rst_i) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= REG_SCRATCH_POWER_ON;
            end
            regs[REG_CPU]   <= REG_CPU_POWER_ON;    // Overrides the loop
            regs[REG_VIDEO] <= REG_VIDEO_POWER_ON;
            ack_q           <= 1'b0;
        end else if (access) begin
            if (wb_req_i.we) begin
                regs[reg_idx] <= wb_req_i.data;
            end
            ack_q <= 1'b1;
        end else begin
            ack_q <= 1'b0;

            // Idle cycle, pick up the current graphics level
            regs[REG_VIDEO][REG_VIDEO_GRAPHICS_BIT] <= video_graphic_i;
        end
    end

    // Read data, old value on a same-cycle write
    always_ff @(posedge wb_clock_i) begin
        if (access) begin
            rd_data_q <= regs[reg_idx];
        end
    end

    always_comb begin
        wb_rsp_o.data  = rd_data_q;
        wb_rsp_o.ack   = ack_q;
        wb_rsp_o.stall = 1'b0;      // Single cycle, never stalls
    end

    // Control pins straight from the register bits
    assign cpu_ready_o = regs[REG_CPU][REG_CPU_READY_BIT];
    assign cpu_reset_o = regs[REG_CPU][REG_CPU_RESET_BIT];
    assign cpu_nmi_o   = regs[REG_CPU][REG_CPU_NMI_BIT];

    assign video_col_80_mode_o = regs[REG_VIDEO][REG_VIDEO_COL_80_BIT];

    // 80 columns opens the second KiB of video RAM
    assign video_ram_mask_o = {1'b0, regs[REG_VIDEO][REG_VIDEO_COL_80_BIT]};
endmodule

// File: source/regmap_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Control register map
// Register indices, bit positions and power-on values
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package regmap_pkg;

    localparam int REG_ADDR_WIDTH = 2;
    localparam int REG_COUNT      = 4;

    typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;    // Register index

    // Indices 2 and 3 are spare scratch bytes
    localparam reg_addr_t REG_CPU   = 2'd0;
    localparam reg_addr_t REG_VIDEO = 2'd1;

    // CPU register bits
    localparam int REG_CPU_READY_BIT = 0;     // RDY pin, 1 = run
    localparam int REG_CPU_RESET_BIT = 1;     // 1 = hold CPU in reset
    localparam int REG_CPU_NMI_BIT   = 2;     // 1 = assert NMI

    // Video register bits
    localparam int REG_VIDEO_COL_80_BIT   = 0;  // 1 = 80 column mode
    localparam int REG_VIDEO_GRAPHICS_BIT = 1;  // Live copy of VIA CA2

    // Power-on values
    // CPU held in reset, not ready, no NMI
    localparam logic [7:0] REG_CPU_POWER_ON     = 8'h02;
    // 40 columns, graphics
    localparam logic [7:0] REG_VIDEO_POWER_ON   = 8'h00;
    localparam logic [7:0] REG_SCRATCH_POWER_ON = 8'h00;

endpackage

// File: source/wb_decoder.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Wishbone address decoder
// Slave selects, response steering, ack for unmapped accesses
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module wb_decoder
    import bus_pkg::*, regmap_pkg::*;
#(
    parameter int RAM_ADDR_WIDTH = 10       // RAM window is 2**RAM_ADDR_WIDTH bytes
) (
    input  logic    wb_clock_i,
    input  logic    rst_i,
    input  wb_req_t bus_req_i,              // From external master
    output wb_rsp_t bus_rsp_o,              // To external master
    output logic    reg_sel_o,
    output logic    ram_sel_o,
    input  wb_rsp_t reg_rsp_i,
    input  wb_rsp_t ram_rsp_i
);
    localparam wb_addr_t REG_LAST = wb_addr_t'(REG_BASE + REG_COUNT - 1);
    localparam wb_addr_t RAM_LAST = wb_addr_t'(RAM_BASE + (2 ** RAM_ADDR_WIDTH) - 1);

    // One-hot record of who took the access
    typedef struct packed {
        logic regs;
        logic ram;
        logic unmapped;
    } target_t;

    logic    access;
    logic    in_reg_win;
    logic    in_ram_win;
    target_t hit;
    target_t target_q;                      // Owner of the response in flight

    assign access     = bus_req_i.cyc && bus_req_i.stb;
    assign in_reg_win = (bus_req_i.addr >= REG_BASE) && (bus_req_i.addr <= REG_LAST);
    assign in_ram_win = (bus_req_i.addr >= RAM_BASE) && (bus_req_i.addr <= RAM_LAST);

    assign reg_sel_o = in_reg_win;
    assign ram_sel_o = in_ram_win && !in_reg_win;   // Register window wins on overlap

    assign hit = '{regs: reg_sel_o, ram: ram_sel_o, unmapped: !reg_sel_o && !ram_sel_o};

    always_ff @(posedge wb_clock_i) begin
        if (rst_i) begin
            target_q <= '0;
        end else if (access) begin
            target_q <= hit;
        end else begin
            target_q <= '0;                 // Idle, nothing to answer next cycle
        end
    end

    // Steer the selected slave back to the master
    always_comb begin
        bus_rsp_o.stall = 1'b0;             // No back-pressure anywhere
        bus_rsp_o.ack   = (target_q.regs && reg_rsp_i.ack)
                        || (target_q.ram && ram_rsp_i.ack)
                        || target_q.unmapped;
        if (target_q.regs) begin
            bus_rsp_o.data = reg_rsp_i.data;
        end else if (target_q.ram) begin
            bus_rsp_o.data = ram_rsp_i.data;
        end else begin
            bus_rsp_o.data = '0;            // Unmapped reads as zero
        end
    end
endmodule

// File: source/wb_ram.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Single-port scratch RAM on the Wishbone bus
// Read-before-write, one-cycle ack
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module wb_ram
    import bus_pkg::*;
#(
    parameter int RAM_ADDR_WIDTH = 10       // 2**RAM_ADDR_WIDTH bytes
) (
    input  logic    wb_clock_i,
    input  wb_req_t wb_req_i,
    input  logic    wb_sel_i,               // Address is in the RAM window
    output wb_rsp_t wb_rsp_o,
    input  logic    rst_i                   // Clears ack, contents untouched
);
    localparam int DEPTH = 2 ** RAM_ADDR_WIDTH;

    wb_data_t                  mem [DEPTH];
    wb_data_t                  rd_data_q;
    logic                      ack_q;
    logic                      access;
    logic [RAM_ADDR_WIDTH-1:0] ram_addr;

    assign access   = wb_sel_i && wb_req_i.cyc && wb_req_i.stb;
    assign ram_addr = wb_req_i.addr[RAM_ADDR_WIDTH-1:0];  // Offset within the window

    // Memory port, read-first
    always_ff @(posedge wb_clock_i) begin
        if (access) begin
            rd_data_q <= mem[ram_addr];     // Old value
            if (wb_req_i.we) begin
                mem[ram_addr] <= wb_req_i.data;
            end
        end
    end

    always_ff @(posedge wb_clock_i) begin
        if (rst_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;                // One cycle after every access
        end
    end

    assign wb_rsp_o = '{data: rd_data_q, ack: ack_q, stall: 1'b0};
endmodule
